// File: rtl/memcopy_cfg.svh
// Memory-copy subsystem constants
// Bus widths, memory geometry and the register map

`ifndef MEMCOPY_CFG_SVH
`define MEMCOPY_CFG_SVH

`define MEMCOPY_DATA_W    32
`define MEMCOPY_ADDR_W    32
`define MEMCOPY_MEM_WORDS 128
`define MEMCOPY_GNT_DELAY 3

// Register offsets
`define MEMCOPY_REG_SRC  4'h0
`define MEMCOPY_REG_DST  4'h4
`define MEMCOPY_REG_SIZE 4'h8
`define MEMCOPY_REG_CTRL 4'hC

`endif

// File: rtl/memcopy_pkg.sv
// Memory-copy subsystem types
// Bus vectors and the copy engine state encoding

package memcopy_pkg;

  `include "memcopy_cfg.svh"

  typedef logic [`MEMCOPY_DATA_W-1:0]     word_t;
  typedef logic [`MEMCOPY_ADDR_W-1:0]     addr_t;
  typedef logic [`MEMCOPY_DATA_W/8-1:0]   be_t;
  typedef logic [3:0]                     reg_addr_t;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT,
    FINISH
  } copy_state_t;

endpackage

// File: rtl/memcopy_ifs.sv
// Memory bus and copy command interfaces
// Bus: req held until gnt, rvalid one cycle after each gnt

`timescale 1ns/1ps

interface bus_if;
  logic               req;
  logic               gnt;
  logic               we;
  memcopy_pkg::addr_t addr;
  memcopy_pkg::word_t wdata;
  memcopy_pkg::be_t   be;
  logic               rvalid;
  memcopy_pkg::word_t rdata;

  modport master (
    output req, we, addr, wdata, be,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, we, addr, wdata, be,
    output gnt, rvalid, rdata
  );
endinterface

interface copy_cmd_if;
  logic               start;
  memcopy_pkg::word_t src;
  memcopy_pkg::word_t dst;
  memcopy_pkg::word_t size;
  logic               busy;
  logic               done;

  // Register side issues the command
  modport ctrl (
    output start, src, dst, size,
    input  busy, done
  );

  modport engine (
    input  start, src, dst, size,
    output busy, done
  );
endinterface

// File: rtl/memcopy_regs.sv
// Copy peripheral register file
// SRC/DST/SIZE registers, CTRL start and status, interrupt flag

`timescale 1ns/1ps
`include "memcopy_cfg.svh"

module memcopy_regs (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  memcopy_pkg::reg_addr_t reg_addr_i,
  input  memcopy_pkg::word_t     reg_wdata_i,
  output memcopy_pkg::word_t     reg_rdata_o,
  output logic                   reg_ready_o,
  output logic                   intr_o,
  copy_cmd_if.ctrl               cmd
);

  logic               access;
  logic               ctrl_sel;
  memcopy_pkg::word_t src_q;
  memcopy_pkg::word_t dst_q;
  memcopy_pkg::word_t size_q;
  memcopy_pkg::word_t rd_value;

  // One access per valid, answered in the following cycle
  assign access   = reg_valid_i && !reg_ready_o;
  assign ctrl_sel = (reg_addr_i == `MEMCOPY_REG_CTRL);

  assign cmd.src  = src_q;
  assign cmd.dst  = dst_q;
  assign cmd.size = size_q;

  always_comb begin
    case (reg_addr_i)
      `MEMCOPY_REG_SRC:  rd_value = src_q;
      `MEMCOPY_REG_DST:  rd_value = dst_q;
      `MEMCOPY_REG_SIZE: rd_value = size_q;
      // Status: busy in bit 0, interrupt flag in bit 1
      `MEMCOPY_REG_CTRL: rd_value = memcopy_pkg::word_t'({intr_o, cmd.busy});
      default:           rd_value = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_ready_o <= 1'b0;
      cmd.start   <= 1'b0;
      intr_o      <= 1'b0;
      src_q       <= '0;
      dst_q       <= '0;
      size_q      <= '0;
    end else begin
      reg_ready_o <= access;
      // Start while busy is dropped
      cmd.start   <= access && reg_write_i && ctrl_sel && reg_wdata_i[0] && !cmd.busy;
      if (access && reg_write_i) begin
        case (reg_addr_i)
          `MEMCOPY_REG_SRC:  src_q  <= reg_wdata_i;
          `MEMCOPY_REG_DST:  dst_q  <= reg_wdata_i;
          `MEMCOPY_REG_SIZE: size_q <= reg_wdata_i;
          default: ;
        endcase
      end
      // A new done wins over the clear from a status read
      if (cmd.done) begin
        intr_o <= 1'b1;
      end else if (access && !reg_write_i && ctrl_sel) begin
        intr_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !reg_write_i) begin
      reg_rdata_o <= rd_value;
    end
  end

  a_ready_single : assert property (@(posedge clk_i) disable iff (reset_i)
    reg_ready_o |=> !reg_ready_o);

endmodule

// File: rtl/memcopy_engine.sv
// Copy engine
// Moves SIZE words from SRC to DST, one bus access in flight at a time

`timescale 1ns/1ps

module memcopy_engine (
  input  logic       clk_i,
  input  logic       reset_i,
  copy_cmd_if.engine cmd,
  bus_if.master      bus
);

  memcopy_pkg::copy_state_t state_q;
  memcopy_pkg::addr_t       src_q;
  memcopy_pkg::addr_t       dst_q;
  memcopy_pkg::word_t       count_q;
  memcopy_pkg::word_t       data_q;

  // Request fields come straight from state and latched values
  assign bus.req   = (state_q == memcopy_pkg::RD_REQ) || (state_q == memcopy_pkg::WR_REQ);
  assign bus.we    = (state_q == memcopy_pkg::WR_REQ);
  assign bus.addr  = (state_q == memcopy_pkg::WR_REQ) ? dst_q : src_q;
  assign bus.wdata = data_q;
  assign bus.be    = '1;

  assign cmd.busy  = (state_q != memcopy_pkg::IDLE);
  assign cmd.done  = (state_q == memcopy_pkg::FINISH);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= memcopy_pkg::IDLE;
    end else begin
      case (state_q)
        memcopy_pkg::IDLE: begin
          if (cmd.start) begin
            // Zero words means nothing to move
            state_q <= (cmd.size == '0) ? memcopy_pkg::FINISH : memcopy_pkg::RD_REQ;
          end
        end
        memcopy_pkg::RD_REQ: begin
          if (bus.gnt) begin
            state_q <= memcopy_pkg::RD_WAIT;
          end
        end
        memcopy_pkg::RD_WAIT: begin
          if (bus.rvalid) begin
            state_q <= memcopy_pkg::WR_REQ;
          end
        end
        memcopy_pkg::WR_REQ: begin
          if (bus.gnt) begin
            state_q <= memcopy_pkg::WR_WAIT;
          end
        end
        memcopy_pkg::WR_WAIT: begin
          if (bus.rvalid) begin
            state_q <= (count_q == memcopy_pkg::word_t'(1)) ? memcopy_pkg::FINISH
                                                            : memcopy_pkg::RD_REQ;
          end
        end
        default: state_q <= memcopy_pkg::IDLE;
      endcase
    end
  end

  // Addresses, word count and the word in transit
  always_ff @(posedge clk_i) begin
    if (state_q == memcopy_pkg::IDLE && cmd.start) begin
      src_q   <= cmd.src;
      dst_q   <= cmd.dst;
      count_q <= cmd.size;
    end
    if (state_q == memcopy_pkg::RD_WAIT && bus.rvalid) begin
      data_q <= bus.rdata;
    end
    if (state_q == memcopy_pkg::WR_WAIT && bus.rvalid) begin
      src_q   <= src_q + memcopy_pkg::addr_t'(4);
      dst_q   <= dst_q + memcopy_pkg::addr_t'(4);
      count_q <= count_q - memcopy_pkg::word_t'(1);
    end
  end

  a_req_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    bus.req && !bus.gnt |=> bus.req && $stable(bus.we) && $stable(bus.addr) &&
                            $stable(bus.wdata) && $stable(bus.be));

endmodule

// File: rtl/bus_arbiter.sv
// Two-master bus arbiter in front of one slave
// Host has priority, choice held until granted, response follows owner

`timescale 1ns/1ps

module bus_arbiter (
  input  logic  clk_i,
  input  logic  reset_i,
  bus_if.slave  host,
  bus_if.slave  copy,
  bus_if.master mem
);

  logic lock_q;
  logic lock_copy_q;
  logic sel_copy;
  logic resp_copy_q;

  // Fresh choice only when nothing is locked
  assign sel_copy = lock_q ? lock_copy_q : (!host.req && copy.req);

  assign mem.req   = sel_copy ? copy.req   : host.req;
  assign mem.we    = sel_copy ? copy.we    : host.we;
  assign mem.addr  = sel_copy ? copy.addr  : host.addr;
  assign mem.wdata = sel_copy ? copy.wdata : host.wdata;
  assign mem.be    = sel_copy ? copy.be    : host.be;

  assign host.gnt = mem.gnt && !sel_copy;
  assign copy.gnt = mem.gnt && sel_copy;

  assign host.rvalid = mem.rvalid && !resp_copy_q;
  assign copy.rvalid = mem.rvalid && resp_copy_q;
  assign host.rdata  = mem.rdata;
  assign copy.rdata  = mem.rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q      <= 1'b0;
      lock_copy_q <= 1'b0;
      resp_copy_q <= 1'b0;
    end else begin
      if (mem.gnt) begin
        lock_q      <= 1'b0;
        resp_copy_q <= sel_copy;
      end else if (mem.req) begin
        lock_q      <= 1'b1;
        lock_copy_q <= sel_copy;
      end
    end
  end

  a_one_grant : assert property (@(posedge clk_i) disable iff (reset_i)
    !(host.gnt && copy.gnt));

endmodule

// File: rtl/slow_memory.sv
// Slow word memory
// Grant after a fixed wait, byte-enabled writes, response one cycle later

`timescale 1ns/1ps
`include "memcopy_cfg.svh"

module slow_memory (
  input  logic clk_i,
  input  logic reset_i,
  bus_if.slave bus
);

  localparam int IdxW   = $clog2(`MEMCOPY_MEM_WORDS);
  localparam int CntW   = $clog2(`MEMCOPY_GNT_DELAY + 1);
  localparam int NBytes = `MEMCOPY_DATA_W / 8;

  memcopy_pkg::word_t mem_q [`MEMCOPY_MEM_WORDS];
  logic [CntW-1:0]    wait_q;
  logic [IdxW-1:0]    idx;

  // Word index from byte address, upper bits ignored
  assign idx     = bus.addr[IdxW+1:2];
  assign bus.gnt = bus.req && (wait_q == CntW'(`MEMCOPY_GNT_DELAY));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_q     <= '0;
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.gnt;
      if (bus.gnt || !bus.req) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + CntW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.gnt) begin
      if (bus.we) begin
        for (int b = 0; b < NBytes; b++) begin
          if (bus.be[b]) begin
            mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
        // Writes echo their data
        bus.rdata <= bus.wdata;
      end else begin
        bus.rdata <= mem_q[idx];
      end
    end
  end

  a_rvalid_after_gnt : assert property (@(posedge clk_i) disable iff (reset_i)
    bus.rvalid |-> $past(bus.gnt));

endmodule

// File: rtl/memcopy_subsystem.sv
// Copy peripheral subsystem top level
// Register port, copy engine and host port sharing one slow memory

`timescale 1ns/1ps

module memcopy_subsystem (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  memcopy_pkg::reg_addr_t reg_addr_i,
  input  memcopy_pkg::word_t     reg_wdata_i,
  output memcopy_pkg::word_t     reg_rdata_o,
  output logic                   reg_ready_o,
  input  logic                   host_req_i,
  input  logic                   host_we_i,
  input  memcopy_pkg::addr_t     host_addr_i,
  input  memcopy_pkg::word_t     host_wdata_i,
  input  memcopy_pkg::be_t       host_be_i,
  output logic                   host_gnt_o,
  output logic                   host_rvalid_o,
  output memcopy_pkg::word_t     host_rdata_o,
  output logic                   intr_o
);

  bus_if      host_bus ();
  bus_if      copy_bus ();
  bus_if      mem_bus ();
  copy_cmd_if cmd ();

  // Host port onto its bus instance
  assign host_bus.req   = host_req_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_bus.be    = host_be_i;
  assign host_gnt_o     = host_bus.gnt;
  assign host_rvalid_o  = host_bus.rvalid;
  assign host_rdata_o   = host_bus.rdata;

  memcopy_regs u_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ready_o (reg_ready_o),
    .intr_o      (intr_o),
    .cmd         (cmd.ctrl)
  );

  memcopy_engine u_engine (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cmd     (cmd.engine),
    .bus     (copy_bus.master)
  );

  bus_arbiter u_arbiter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .host    (host_bus.slave),
    .copy    (copy_bus.slave),
    .mem     (mem_bus.master)
  );

  slow_memory u_memory (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (mem_bus.slave)
  );

endmodule

// File: tb/clk_gen.sv
// Testbench clock and reset source
// 4 ns clock, reset held high for the first two rising edges

`timescale 1ns/1ps

module clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

  always #2 clk_o = ~clk_o;

endmodule

// File: tb/tb_memcopy.sv
// Memory-copy subsystem testbench
// Directed register, host bus and copy tests against a local memory model

`timescale 1ns/1ps
`include "memcopy_cfg.svh"

module tb_memcopy;

  // Tests need about 3000 cycles, so this leaves a wide margin
  localparam int TimeoutCycles = 20000;

  logic                   clk;
  logic                   reset;
  logic                   reg_valid;
  logic                   reg_wr;
  memcopy_pkg::reg_addr_t reg_addr;
  memcopy_pkg::word_t     reg_wdata;
  memcopy_pkg::word_t     reg_rdata;
  logic                   reg_ready;
  logic                   host_req;
  logic                   host_we;
  memcopy_pkg::addr_t     host_addr;
  memcopy_pkg::word_t     host_wdata;
  memcopy_pkg::be_t       host_be;
  logic                   host_gnt;
  logic                   host_rvalid;
  memcopy_pkg::word_t     host_rdata;
  logic                   intr;

  memcopy_pkg::word_t model [`MEMCOPY_MEM_WORDS];
  memcopy_pkg::word_t rng_state = 32'h4b40d3ab;
  int                 cycles = 0;
  int                 checks = 0;
  int                 errors = 0;

  clk_gen u_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  memcopy_subsystem DUT (
    .clk_i         (clk),
    .reset_i       (reset),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_wr),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .reg_ready_o   (reg_ready),
    .host_req_i    (host_req),
    .host_we_i     (host_we),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_be_i     (host_be),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .intr_o        (intr)
  );

  // Xorshift32 stream
  function automatic memcopy_pkg::word_t rand_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int word_index(input memcopy_pkg::addr_t addr);
    return int'(addr[8:2]);
  endfunction

  function automatic memcopy_pkg::word_t merge_bytes(input memcopy_pkg::word_t old_word,
                                                     input memcopy_pkg::word_t new_word,
                                                     input memcopy_pkg::be_t be);
    memcopy_pkg::word_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic check_value(input string name, input memcopy_pkg::word_t got,
                             input memcopy_pkg::word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic reg_write(input memcopy_pkg::reg_addr_t addr, input memcopy_pkg::word_t data);
    @(posedge clk);
    #1;
    reg_valid = 1'b1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    while (!reg_ready) @(negedge clk);
    @(posedge clk);
    #1;
    reg_valid = 1'b0;
    reg_wr    = 1'b0;
  endtask

  task automatic reg_read(input memcopy_pkg::reg_addr_t addr, output memcopy_pkg::word_t data);
    @(posedge clk);
    #1;
    reg_valid = 1'b1;
    reg_wr    = 1'b0;
    reg_addr  = addr;
    @(negedge clk);
    while (!reg_ready) @(negedge clk);
    data = reg_rdata;
    @(posedge clk);
    #1;
    reg_valid = 1'b0;
  endtask

  task automatic check_ctrl(input memcopy_pkg::word_t exp);
    memcopy_pkg::word_t value;
    reg_read(`MEMCOPY_REG_CTRL, value);
    check_value("reg_rdata_o (CTRL)", value, exp);
  endtask

  // One host bus access; request held until grant, response one cycle later
  task automatic host_access(input logic we, input memcopy_pkg::addr_t addr,
                             input memcopy_pkg::word_t wdata, input memcopy_pkg::be_t be,
                             output memcopy_pkg::word_t rdata);
    @(posedge clk);
    #1;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    host_be    = be;
    @(negedge clk);
    while (!host_gnt) @(negedge clk);
    checks++;
    assert (!host_rvalid) else begin
      $display("host_rvalid_o was high in the grant cycle at 0x%08h", addr);
      errors++;
    end
    @(posedge clk);
    #1;
    host_req = 1'b0;
    @(negedge clk);
    checks++;
    assert (host_rvalid) else begin
      $display("host_rvalid_o did not follow host_gnt_o by one cycle at 0x%08h", addr);
      errors++;
    end
    rdata = host_rdata;
  endtask

  task automatic mem_write(input memcopy_pkg::addr_t addr, input memcopy_pkg::word_t data,
                           input memcopy_pkg::be_t be);
    memcopy_pkg::word_t unused;
    host_access(1'b1, addr, data, be, unused);
    model[word_index(addr)] = merge_bytes(model[word_index(addr)], data, be);
  endtask

  task automatic mem_read(input memcopy_pkg::addr_t addr);
    memcopy_pkg::word_t data;
    host_access(1'b0, addr, '0, '0, data);
    check_value($sformatf("host_rdata_o[0x%03h]", addr), data, model[word_index(addr)]);
  endtask

  task automatic wait_intr();
    @(negedge clk);
    while (!intr) @(negedge clk);
  endtask

  task automatic model_copy(input memcopy_pkg::addr_t src, input memcopy_pkg::addr_t dst,
                            input int words);
    for (int i = 0; i < words; i++) begin
      model[word_index(dst + memcopy_pkg::addr_t'(4*i))] =
        model[word_index(src + memcopy_pkg::addr_t'(4*i))];
    end
  endtask

  task automatic start_copy(input memcopy_pkg::addr_t src, input memcopy_pkg::addr_t dst,
                            input int words);
    reg_write(`MEMCOPY_REG_SRC, src);
    reg_write(`MEMCOPY_REG_DST, dst);
    reg_write(`MEMCOPY_REG_SIZE, memcopy_pkg::word_t'(words));
    reg_write(`MEMCOPY_REG_CTRL, 32'h1);
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (errors == start_errors) $display("%s: passed", name);
    else $display("%s: failed with %0d errors", name, errors - start_errors);
  endtask

  task automatic fill_memory();
    memcopy_pkg::addr_t addr;
    for (int i = 0; i < `MEMCOPY_MEM_WORDS; i++) begin
      addr = memcopy_pkg::addr_t'(4*i);
      mem_write(addr, rand_word() ^ addr, 4'hF);
    end
  endtask

  task automatic test_registers();
    memcopy_pkg::word_t values [3];
    memcopy_pkg::word_t value;
    check_value("reg_ready_o", memcopy_pkg::word_t'(reg_ready), '0);
    check_value("host_gnt_o", memcopy_pkg::word_t'(host_gnt), '0);
    check_value("intr_o", memcopy_pkg::word_t'(intr), '0);
    for (int i = 0; i < 3; i++) values[i] = rand_word();
    reg_write(`MEMCOPY_REG_SRC, values[0]);
    reg_write(`MEMCOPY_REG_DST, values[1]);
    reg_write(`MEMCOPY_REG_SIZE, values[2]);
    reg_read(`MEMCOPY_REG_SRC, value);
    check_value("reg_rdata_o (SRC)", value, values[0]);
    reg_read(`MEMCOPY_REG_DST, value);
    check_value("reg_rdata_o (DST)", value, values[1]);
    reg_read(`MEMCOPY_REG_SIZE, value);
    check_value("reg_rdata_o (SIZE)", value, values[2]);
    check_ctrl(32'h0);
  endtask

  task automatic test_byte_enables();
    for (int i = 0; i < 8; i++) begin
      mem_write(memcopy_pkg::addr_t'(32'h1C0 + 4*i), rand_word(), memcopy_pkg::be_t'(i*3 + 1));
    end
    for (int i = 0; i < 8; i++) mem_read(memcopy_pkg::addr_t'(32'h1C0 + 4*i));
  endtask

  task automatic test_copy();
    for (int i = 0; i < 16; i++) mem_write(memcopy_pkg::addr_t'(4*i), rand_word(), 4'hF);
    start_copy(32'h000, 32'h100, 16);
    wait_intr();
    model_copy(32'h000, 32'h100, 16);
    check_ctrl(32'h2);
    check_ctrl(32'h0);
    // Destination plus two words on each side
    for (int i = 62; i < 82; i++) mem_read(memcopy_pkg::addr_t'(4*i));
  endtask

  task automatic test_zero_size();
    start_copy(32'h000, 32'h080, 0);
    wait_intr();
    check_ctrl(32'h2);
    check_ctrl(32'h0);
    for (int i = 0; i < `MEMCOPY_MEM_WORDS; i++) mem_read(memcopy_pkg::addr_t'(4*i));
  endtask

  task automatic test_busy_traffic();
    for (int i = 0; i < 8; i++) mem_write(memcopy_pkg::addr_t'(32'h040 + 4*i), rand_word(), 4'hF);
    start_copy(32'h040, 32'h180, 8);
    for (int i = 0; i < 4; i++) mem_read(memcopy_pkg::addr_t'(32'h1E0 + 4*i));
    check_ctrl(32'h1);
    // Second start while busy, with a larger size
    reg_write(`MEMCOPY_REG_SIZE, 32'd16);
    reg_write(`MEMCOPY_REG_CTRL, 32'h1);
    check_ctrl(32'h1);
    wait_intr();
    model_copy(32'h040, 32'h180, 8);
    check_ctrl(32'h2);
    for (int i = 96; i < 112; i++) mem_read(memcopy_pkg::addr_t'(4*i));
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int start_errors;
    reg_valid  = 1'b0;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_be    = '0;
    @(negedge clk);
    while (reset) @(negedge clk);

    start_errors = errors;
    test_registers();
    report_test("test_registers", start_errors);
    fill_memory();
    start_errors = errors;
    test_byte_enables();
    report_test("test_byte_enables", start_errors);
    start_errors = errors;
    test_copy();
    report_test("test_copy", start_errors);
    start_errors = errors;
    test_zero_size();
    report_test("test_zero_size", start_errors);
    start_errors = errors;
    test_busy_traffic();
    report_test("test_busy_traffic", start_errors);

    $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/memcopy_pkg.sv
rtl/memcopy_ifs.sv
rtl/memcopy_regs.sv
rtl/memcopy_engine.sv
rtl/bus_arbiter.sv
rtl/slow_memory.sv
rtl/memcopy_subsystem.sv
tb/clk_gen.sv
tb/tb_memcopy.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the memory-copy testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_memcopy -f verilog.f -o sim_tb_memcopy

./obj_dir/sim_tb_memcopy | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
